// File: project.f
src/fifo_pkg.sv
src/ecc_pkg.sv
src/ecc_encoder.sv
src/ecc_decoder.sv
src/tp_ram.sv
src/ram_fifo.sv
src/fwft_prefetch.sv
src/video_line_fifo.sv
tests/tb_video_line_fifo.sv

// File: tests/tb_video_line_fifo.sv
`default_nettype none

module tb_video_line_fifo
    import fifo_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DW    = DEF_DATA_WIDTH;
    localparam int AW    = DEF_ADDR_WIDTH;
    localparam int DEPTH = 2 ** AW;
    localparam int SLOTS = prefetch_slots(DEF_RAM_PIPE_STAGE);
    localparam int PF_ASSERT = 12;
    localparam int PF_NEGATE = 6;

    // rough cycle budget of each test with its drain
    localparam int LEN_RESET = 20;
    localparam int LEN_BURST = 500;
    localparam int LEN_FILL  = 120;
    localparam int LEN_PROG  = 200;
    localparam int LEN_ECC   = 200;
    localparam int LEN_ADDR  = 300;
    localparam int LEN_TOTAL = LEN_RESET + LEN_BURST + LEN_FILL + LEN_PROG + LEN_ECC + LEN_ADDR;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          wr_en, rd_en;
    logic [DW-1:0] wr_data;
    logic [AW:0]   prog_full_assert_cfg, prog_full_negate_cfg;
    logic          ecc_addr_protect_en, ecc_fault_detc_en, ecc_bypass;
    logic          inject_single, inject_double;
    logic [DW-1:0] rd_data;
    logic          rd_data_val, empty, full, prog_full, ovf_int, udf_int;
    logic          ecc_fault, single_err, double_err;

    logic [DW-1:0] model_q [$];     // words still owed to the reader
    logic [DW-1:0] exp_head;
    int            n_accepted, n_read, n_single, n_double, n_fault;
    string         test_name = "reset";

    always #2 clk = ~clk;   // 4 ns period

    video_line_fifo video_line_fifo_i (.*);

    // ----------------------------------------------------------------------
    // failure reporting
    // ----------------------------------------------------------------------
    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report(input string what, input logic [DW-1:0] exp, input logic [DW-1:0] act);
        $display("CHECK FAILED %s %s: expected %0h actual %0h", test_name, what, exp, act);
        abort_run();
    endtask

    task automatic check_eq(input string what, input logic [DW-1:0] exp, input logic [DW-1:0] act);
        assert (exp === act) else report(what, exp, act);
    endtask

    // ----------------------------------------------------------------------
    // reference model of the words the reader should see
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (rd_en && rd_data_val && model_q.size() > 0) begin
                void'(model_q.pop_front());
                n_read++;
            end
            if (wr_en && !full) begin
                if (inject_double)
                    model_q.push_back(wr_data ^ 32'h3);     // left uncorrected
                else if (inject_single && ecc_bypass)
                    model_q.push_back(wr_data ^ 32'h1);
                else
                    model_q.push_back(wr_data);
                n_accepted++;
            end
            n_single += single_err;
            n_double += double_err;
            n_fault  += ecc_fault;
            exp_head = (model_q.size() > 0) ? model_q[0] : '0;
        end
    end

    a_data: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en && rd_data_val |-> rd_data == exp_head)
        else report("rd_data", $sampled(exp_head), $sampled(rd_data));
    a_empty: assert property (@(posedge clk) disable iff (!rst_n)
        empty == !rd_data_val)
        else report("empty", !$sampled(rd_data_val), $sampled(empty));
    a_ovf: assert property (@(posedge clk) disable iff (!rst_n)
        ovf_int == $past(wr_en && full))
        else report("ovf_int", !$sampled(ovf_int), $sampled(ovf_int));
    a_udf: assert property (@(posedge clk) disable iff (!rst_n)
        udf_int == $past(rd_en && empty))
        else report("udf_int", !$sampled(udf_int), $sampled(udf_int));

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            wr_en <= 1'b0;
            rd_en <= 1'b0;
        end
    endtask

    task automatic write_n(input int n, input logic inj_s, input logic inj_d);
        repeat (n) begin
            @(posedge clk);
            wr_en         <= 1'b1;
            wr_data       <= $urandom;
            inject_single <= inj_s;
            inject_double <= inj_d;
        end
        @(posedge clk);
        wr_en         <= 1'b0;
        inject_single <= 1'b0;
        inject_double <= 1'b0;
    endtask

    // consumes exactly n words and drops rd_en on the last consuming edge
    task automatic read_n(input int n);
        int  target;
        bit  last;
        target = n_read + n;
        if (n == 0)
            return;
        @(posedge clk);
        rd_en <= 1'b1;
        for (int i = 0; i < 400; i++) begin
            @(negedge clk);
            last = rd_data_val && (n_read + 1 >= target);
            @(posedge clk);
            if (last) begin
                rd_en <= 1'b0;
                return;
            end
        end
        $display("reader stalled, words never came out of the fifo");
        abort_run();
    endtask

    task automatic drain();
        @(negedge clk);
        read_n(model_q.size());
        idle(4);
    endtask

    task automatic random_burst(input int n);
        repeat (n) begin
            @(posedge clk);
            wr_en   <= $urandom % 2;
            wr_data <= $urandom;
            rd_en   <= ($urandom % 3) != 0;
        end
        @(posedge clk);
        wr_en <= 1'b0;
        rd_en <= 1'b0;
    endtask

    task automatic clear_counts();
        @(negedge clk);
        n_single = 0;
        n_double = 0;
        n_fault  = 0;
    endtask

    // one corrupted word and the pulse counts over its trip
    task automatic ecc_case(input string name, input logic inj_s, input logic inj_d,
                            input int exp_single, input int exp_double);
        test_name = name;
        clear_counts();
        write_n(1, inj_s, inj_d);
        idle(12);
        drain();
        check_eq("single_err pulses", exp_single, n_single);
        check_eq("double_err pulses", exp_double, n_double);
        check_eq("ecc_fault pulses", exp_single + exp_double, n_fault);
    endtask

    task automatic check_prog_full(input logic exp);
        idle(12);
        @(negedge clk);
        check_eq("prog_full", exp, prog_full);
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(32'h2f19));
        rst_n = 1'b0;
        wr_en = 1'b0;
        rd_en = 1'b0;
        wr_data = '0;
        prog_full_assert_cfg = PF_ASSERT;
        prog_full_negate_cfg = PF_NEGATE;
        ecc_addr_protect_en = 1'b0;
        ecc_fault_detc_en = 1'b1;
        ecc_bypass = 1'b0;
        inject_single = 1'b0;
        inject_double = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_eq("empty after reset", 1, empty);
        check_eq("flags after reset",
                 0, {rd_data_val, full, prog_full, ovf_int, udf_int, ecc_fault});

        test_name = "order";
        random_burst(400);
        drain();

        test_name = "fill";
        n_accepted = 0;
        write_n(DEPTH + SLOTS + 10, 1'b0, 1'b0);   // tail runs into full and raises ovf
        @(negedge clk);
        check_eq("full", 1, full);
        check_eq("accepted words", DEPTH + SLOTS, n_accepted);
        drain();
        idle(2);
        @(posedge clk);
        rd_en <= 1'b1;  // underflow pulse
        idle(2);

        test_name = "prog_full";
        write_n(SLOTS + 14, 1'b0, 1'b0);   // core count 14
        check_prog_full(1'b1);
        read_n(6);                          // 8 and held
        check_prog_full(1'b1);
        read_n(6);                          // 2
        check_prog_full(1'b0);
        write_n(8, 1'b0, 1'b0);             // 10 and held low
        check_prog_full(1'b0);
        drain();

        ecc_case("single", 1'b1, 1'b0, 1, 0);
        @(posedge clk);
        ecc_fault_detc_en <= 1'b0;
        ecc_case("single_nodetect", 1'b1, 1'b0, 0, 0);
        @(posedge clk);
        ecc_fault_detc_en <= 1'b1;
        ecc_case("double", 1'b0, 1'b1, 0, 1);
        @(posedge clk);
        ecc_bypass <= 1'b1;
        ecc_case("bypass", 1'b1, 1'b0, 1, 0);
        @(posedge clk);
        ecc_bypass <= 1'b0;

        test_name = "addr_protect";
        @(posedge clk);
        ecc_addr_protect_en <= 1'b1;
        clear_counts();
        random_burst(250);
        drain();
        check_eq("ecc_fault pulses", 0, n_fault);

        $display("PASS: all tests");
        $finish;
    end

    initial begin
        #(LEN_TOTAL * 4 * 4);
        $display("watchdog expired, the run took too long");
        abort_run();
    end

endmodule

`default_nettype wire

// File: src/video_line_fifo.sv
`default_nettype none

module video_line_fifo
    import fifo_pkg::*;
#(
    parameter int DATA_WIDTH     = DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH     = DEF_ADDR_WIDTH,
    parameter int RAM_PIPE_STAGE = DEF_RAM_PIPE_STAGE
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH:0]   prog_full_assert_cfg,
    input  logic [ADDR_WIDTH:0]   prog_full_negate_cfg,
    input  logic                  ecc_addr_protect_en,
    input  logic                  ecc_fault_detc_en,
    input  logic                  ecc_bypass,
    input  logic                  inject_single,
    input  logic                  inject_double,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  rd_data_val,
    output logic                  empty,
    output logic                  full,
    output logic                  prog_full,
    output logic                  ovf_int,
    output logic                  udf_int,
    output logic                  ecc_fault,
    output logic                  single_err,
    output logic                  double_err
);

    logic                  core_rd_en;
    logic [DATA_WIDTH-1:0] core_rd_data;
    logic                  core_rd_val;
    logic                  core_empty;

    assign empty = ~rd_data_val;

    // one-cycle pulses on requests against the external flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ovf_int <= 1'b0;
            udf_int <= 1'b0;
        end else begin
            ovf_int <= wr_en & full;
            udf_int <= rd_en & empty;
        end
    end

    ram_fifo #(
        .DATA_WIDTH     ( DATA_WIDTH     ),
        .ADDR_WIDTH     ( ADDR_WIDTH     ),
        .RAM_PIPE_STAGE ( RAM_PIPE_STAGE )
    ) core_i (
        .clk                  ( clk                  ),
        .rst_n                ( rst_n                ),
        .wr_en                ( wr_en                ),
        .wr_data              ( wr_data              ),
        .core_rd_en           ( core_rd_en           ),
        .prog_full_assert_cfg ( prog_full_assert_cfg ),
        .prog_full_negate_cfg ( prog_full_negate_cfg ),
        .ecc_addr_protect_en  ( ecc_addr_protect_en  ),
        .ecc_fault_detc_en    ( ecc_fault_detc_en    ),
        .ecc_bypass           ( ecc_bypass           ),
        .inject_single        ( inject_single        ),
        .inject_double        ( inject_double        ),
        .core_rd_data         ( core_rd_data         ),
        .core_rd_val          ( core_rd_val          ),
        .core_empty           ( core_empty           ),
        .full                 ( full                 ),
        .prog_full            ( prog_full            ),
        .ecc_fault            ( ecc_fault            ),
        .single_err           ( single_err           ),
        .double_err           ( double_err           )
    );

    fwft_prefetch #(
        .DATA_WIDTH     ( DATA_WIDTH     ),
        .RAM_PIPE_STAGE ( RAM_PIPE_STAGE )
    ) prefetch_i (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .core_empty   ( core_empty   ),
        .core_rd_data ( core_rd_data ),
        .core_rd_val  ( core_rd_val  ),
        .rd_en        ( rd_en        ),
        .core_rd_en   ( core_rd_en   ),
        .rd_data      ( rd_data      ),
        .rd_data_val  ( rd_data_val  )
    );

endmodule

`default_nettype wire

// File: src/fwft_prefetch.sv
`default_nettype none

module fwft_prefetch
    import fifo_pkg::*;
#(
    parameter int DATA_WIDTH     = DEF_DATA_WIDTH,
    parameter int RAM_PIPE_STAGE = DEF_RAM_PIPE_STAGE
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  core_empty,
    input  logic [DATA_WIDTH-1:0] core_rd_data,
    input  logic                  core_rd_val,
    input  logic                  rd_en,
    output logic                  core_rd_en,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  rd_data_val
);

    localparam int SLOTS = prefetch_slots(RAM_PIPE_STAGE);
    localparam int LAT   = RAM_PIPE_STAGE + 1;     // ram stages + decoder reg
    localparam logic [SLOTS-1:0] SLOT0 = SLOTS'(1);

    logic [SLOTS-1:0]      fill_ptr;
    logic [SLOTS-1:0]      drain_ptr;
    logic [SLOTS-1:0]      fill_dly [LAT];
    logic [SLOTS-1:0]      land_ptr;
    logic [SLOTS-1:0]      slot_val;
    logic [DATA_WIDTH-1:0] slot_data [SLOTS];
    logic                  consume;

    assign consume  = rd_en & rd_data_val;
    assign land_ptr = fill_dly[LAT-1];

    // issue only into a free slot
    assign core_rd_en = ~core_empty & ~(|(fill_ptr & slot_val));

    // ----------------------------------------------------------------------
    // one-hot pointers, fill pointer delayed to match read latency
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_ptr  <= SLOT0;
            drain_ptr <= SLOT0;
            for (int i = 0; i < LAT; i++) begin
                fill_dly[i] <= SLOT0;
            end
        end else begin
            if (core_rd_en)
                fill_ptr <= {fill_ptr[SLOTS-2:0], fill_ptr[SLOTS-1]};
            if (consume)
                drain_ptr <= {drain_ptr[SLOTS-2:0], drain_ptr[SLOTS-1]};
            fill_dly[0] <= fill_ptr;
            for (int i = 1; i < LAT; i++) begin
                fill_dly[i] <= fill_dly[i-1];
            end
        end
    end

    // ----------------------------------------------------------------------
    // slot ring
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_val <= '0;
        end else begin
            for (int i = 0; i < SLOTS; i++) begin
                if (core_rd_val && land_ptr[i])
                    slot_val[i] <= 1'b1;
                else if (consume && drain_ptr[i])
                    slot_val[i] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SLOTS; i++) begin
            if (core_rd_val && land_ptr[i])
                slot_data[i] <= core_rd_data;
        end
    end

    // and-or mux on the drain pointer
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < SLOTS; i++) begin
            rd_data = rd_data | (slot_data[i] & {DATA_WIDTH{drain_ptr[i]}});
        end
    end

    assign rd_data_val = |(drain_ptr & slot_val);

    // a returning word must find its slot still free
    a_land_free: assert property (@(posedge clk) disable iff (!rst_n)
        core_rd_val |-> !(|(land_ptr & slot_val)));
    // head word holds while the consumer stalls
    a_head_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rd_data_val && !rd_en |=> rd_data_val && $stable(rd_data));

endmodule

`default_nettype wire

// File: src/ram_fifo.sv
`default_nettype none

module ram_fifo
    import fifo_pkg::*, ecc_pkg::*;
#(
    parameter int DATA_WIDTH     = DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH     = DEF_ADDR_WIDTH,
    parameter int RAM_PIPE_STAGE = DEF_RAM_PIPE_STAGE
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic                  core_rd_en,
    input  logic [ADDR_WIDTH:0]   prog_full_assert_cfg,
    input  logic [ADDR_WIDTH:0]   prog_full_negate_cfg,
    input  logic                  ecc_addr_protect_en,
    input  logic                  ecc_fault_detc_en,
    input  logic                  ecc_bypass,
    input  logic                  inject_single,
    input  logic                  inject_double,
    output logic [DATA_WIDTH-1:0] core_rd_data,
    output logic                  core_rd_val,
    output logic                  core_empty,
    output logic                  full,
    output logic                  prog_full,
    output logic                  ecc_fault,
    output logic                  single_err,
    output logic                  double_err
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;
    localparam int CNT_W = count_width(ADDR_WIDTH);
    localparam int CW    = codeword_width(DATA_WIDTH, ADDR_WIDTH);

    logic [ADDR_WIDTH-1:0] wptr;
    logic [ADDR_WIDTH-1:0] rptr;
    logic [CNT_W-1:0]      count;
    logic [CNT_W-1:0]      count_nxt;
    logic                  wen;
    logic [CW-1:0]         wr_word;
    logic [CW-1:0]         rd_word;
    logic                  rd_val;
    logic [ADDR_WIDTH-1:0] tag_pipe [RAM_PIPE_STAGE];
    ecc_status_e           status;

    // ----------------------------------------------------------------------
    // pointers and occupancy
    // ----------------------------------------------------------------------
    assign wen        = wr_en & ~full;        // only gating of writes
    assign full       = (count == CNT_W'(DEPTH));
    assign core_empty = (count == '0);

    always_comb begin
        count_nxt = count;
        case ({wen, core_rd_en})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wptr      <= '0;
            rptr      <= '0;
            count     <= '0;
            prog_full <= 1'b0;
        end else begin
            if (wen)
                wptr <= wptr + 1'b1;
            if (core_rd_en)
                rptr <= rptr + 1'b1;
            count <= count_nxt;
            // hysteresis, between the two thresholds the flag holds
            if (count_nxt >= prog_full_assert_cfg)
                prog_full <= 1'b1;
            else if (count_nxt < prog_full_negate_cfg)
                prog_full <= 1'b0;
        end
    end

    // read address rides along with the ram pipeline
    always_ff @(posedge clk) begin
        tag_pipe[0] <= rptr;
        for (int s = 1; s < RAM_PIPE_STAGE; s++) begin
            tag_pipe[s] <= tag_pipe[s-1];
        end
    end

    // ----------------------------------------------------------------------
    // storage path
    // ----------------------------------------------------------------------
    ecc_encoder #(
        .DATA_WIDTH      ( DATA_WIDTH          ),
        .ADDR_WIDTH      ( ADDR_WIDTH          )
    ) encoder_i (
        .wr_data         ( wr_data             ),
        .wr_addr         ( wptr                ),
        .addr_protect_en ( ecc_addr_protect_en ),
        .inject_single   ( inject_single       ),
        .inject_double   ( inject_double       ),
        .codeword        ( wr_word             )
    );

    tp_ram #(
        .WORD_WIDTH     ( CW             ),
        .ADDR_WIDTH     ( ADDR_WIDTH     ),
        .RAM_PIPE_STAGE ( RAM_PIPE_STAGE )
    ) ram_i (
        .clk     ( clk        ),
        .wr_en   ( wen        ),
        .wr_addr ( wptr       ),
        .wr_word ( wr_word    ),
        .rd_en   ( core_rd_en ),
        .rd_addr ( rptr       ),
        .rd_word ( rd_word    ),
        .rd_val  ( rd_val     )
    );

    ecc_decoder #(
        .DATA_WIDTH      ( DATA_WIDTH          ),
        .ADDR_WIDTH      ( ADDR_WIDTH          )
    ) decoder_i (
        .clk             ( clk                 ),
        .rst_n           ( rst_n               ),
        .rd_word         ( rd_word             ),
        .rd_val          ( rd_val              ),
        .rd_addr_tag     ( tag_pipe[RAM_PIPE_STAGE-1] ),
        .addr_protect_en ( ecc_addr_protect_en ),
        .bypass          ( ecc_bypass          ),
        .detect_en       ( ecc_fault_detc_en   ),
        .data            ( core_rd_data        ),
        .data_val        ( core_rd_val         ),
        .status          ( status              )
    );

    assign single_err = (status == ECC_SINGLE);
    assign double_err = (status == ECC_DOUBLE);
    assign ecc_fault  = single_err | double_err;

    // the prefetch decides when to read, the core only counts
    a_no_empty_read: assert property (@(posedge clk) disable iff (!rst_n)
        core_rd_en |-> !core_empty);
    a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: src/tp_ram.sv
`default_nettype none

module tp_ram
    import fifo_pkg::*;
#(
    parameter int WORD_WIDTH     = DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH     = DEF_ADDR_WIDTH,
    parameter int RAM_PIPE_STAGE = DEF_RAM_PIPE_STAGE
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [ADDR_WIDTH-1:0] wr_addr,
    input  logic [WORD_WIDTH-1:0] wr_word,
    input  logic                  rd_en,
    input  logic [ADDR_WIDTH-1:0] rd_addr,
    output logic [WORD_WIDTH-1:0] rd_word,
    output logic                  rd_val
);

    logic [WORD_WIDTH-1:0]     mem [2**ADDR_WIDTH];
    logic [WORD_WIDTH-1:0]     pipe_word [RAM_PIPE_STAGE];
    logic [RAM_PIPE_STAGE-1:0] pipe_val;

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_word;
    end

    // stage 0 is the array read, the rest model the macro output flops
    always_ff @(posedge clk) begin
        pipe_val[0] <= rd_en;
        if (rd_en)
            pipe_word[0] <= mem[rd_addr];
        for (int s = 1; s < RAM_PIPE_STAGE; s++) begin
            pipe_val[s]  <= pipe_val[s-1];
            pipe_word[s] <= pipe_word[s-1];
        end
    end

    assign rd_word = pipe_word[RAM_PIPE_STAGE-1];
    assign rd_val  = pipe_val[RAM_PIPE_STAGE-1];

    // the core flags keep read and write apart; with one word stored the
    // pointers differ, so a shared address means the fifo gating broke
    a_no_collide: assert property (@(posedge clk)
        wr_en && rd_en |-> wr_addr != rd_addr);

endmodule

`default_nettype wire

// File: src/ecc_decoder.sv
`default_nettype none

module ecc_decoder
    import fifo_pkg::*, ecc_pkg::*;
#(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic [codeword_width(DATA_WIDTH, ADDR_WIDTH)-1:0] rd_word,
    input  logic                                            rd_val,
    input  logic [ADDR_WIDTH-1:0]                           rd_addr_tag,
    input  logic                                            addr_protect_en,
    input  logic                                            bypass,
    input  logic                                            detect_en,
    output logic [DATA_WIDTH-1:0]                           data,
    output logic                                            data_val,
    output ecc_status_e                                     status
);

    localparam int CW = codeword_width(DATA_WIDTH, ADDR_WIDTH);
    localparam int R  = check_bits(DATA_WIDTH, ADDR_WIDTH) - 1;
    localparam int K  = DATA_WIDTH + ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] rx_data;
    logic [DATA_WIDTH-1:0] fixed;
    logic [R-1:0]          syndrome;
    logic [CW-1:0]         recalc;
    logic                  p_err;
    ecc_status_e           raw_st;
    ecc_status_e           st;

    assign rx_data = rd_word[DATA_WIDTH-1:0];

    // same encoder as the write side, so both agree on the bit map
    ecc_encoder #(
        .DATA_WIDTH      ( DATA_WIDTH      ),
        .ADDR_WIDTH      ( ADDR_WIDTH      )
    ) recalc_i (
        .wr_data         ( rx_data         ),
        .wr_addr         ( rd_addr_tag     ),
        .addr_protect_en ( addr_protect_en ),
        .inject_single   ( 1'b0            ),
        .inject_double   ( 1'b0            ),
        .codeword        ( recalc          )
    );

    assign syndrome = recalc[CW-2:DATA_WIDTH] ^ rd_word[CW-2:DATA_WIDTH];
    assign p_err    = recalc[CW-1] ^ rd_word[CW-1] ^ (^syndrome);  // whole-word parity

    always_comb begin
        if (!p_err && syndrome == '0)
            raw_st = ECC_OK;
        else if (p_err)
            raw_st = ECC_SINGLE;    // syndrome 0 here means the parity bit itself
        else
            raw_st = ECC_DOUBLE;
    end

    assign st = (detect_en && rd_val) ? raw_st : ECC_OK;

    // flip the data bit that sits at the syndrome position
    always_comb begin : correct
        int k;
        fixed = rx_data;
        k     = 0;
        for (int p = 1; p <= K + R; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (k < DATA_WIDTH && syndrome == p && raw_st == ECC_SINGLE && !bypass)
                    fixed[k] = ~fixed[k];
                k++;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_val <= 1'b0;
            status   <= ECC_OK;
        end else begin
            data_val <= rd_val;
            status   <= st;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_val)
            data <= fixed;
    end

endmodule

`default_nettype wire

// File: src/ecc_encoder.sv
`default_nettype none

module ecc_encoder
    import fifo_pkg::*, ecc_pkg::*;
#(
    parameter int DATA_WIDTH = DEF_DATA_WIDTH,
    parameter int ADDR_WIDTH = DEF_ADDR_WIDTH
) (
    input  logic [DATA_WIDTH-1:0]                           wr_data,
    input  logic [ADDR_WIDTH-1:0]                           wr_addr,
    input  logic                                            addr_protect_en,
    input  logic                                            inject_single,
    input  logic                                            inject_double,
    output logic [codeword_width(DATA_WIDTH, ADDR_WIDTH)-1:0] codeword
);

    localparam int R  = check_bits(DATA_WIDTH, ADDR_WIDTH) - 1;  // without parity
    localparam int K  = DATA_WIDTH + ADDR_WIDTH;
    localparam int CW = codeword_width(DATA_WIDTH, ADDR_WIDTH);

    logic [K-1:0] msg;
    logic [R-1:0] chk;
    logic         parity;
    logic [1:0]   flip;

    assign msg = {wr_addr & {ADDR_WIDTH{addr_protect_en}}, wr_data};

    // message bits sit on the non power of two hamming positions
    always_comb begin : hamming
        int k;
        chk = '0;
        k   = 0;
        for (int p = 1; p <= K + R; p++) begin
            if ((p & (p - 1)) != 0) begin
                for (int j = 0; j < R; j++) begin
                    if (p[j]) chk[j] = chk[j] ^ msg[k];
                end
                k++;
            end
        end
    end

    assign parity = ^{msg, chk};

    // self-test corruption, bit 0 alone or bits 0 and 1
    assign flip     = {inject_double, inject_single | inject_double};
    assign codeword = {parity, chk, wr_data} ^ CW'(flip);

endmodule

`default_nettype wire

// File: src/ecc_pkg.sv
`default_nettype none

package ecc_pkg;

    // ----------------------------------------------------------------------
    // secded sizing
    // ----------------------------------------------------------------------

    // hamming bits over data + address, plus one overall parity bit
    function automatic int check_bits(input int data_w, input int addr_w);
        int r;
        r = 1;
        while ((1 << r) < data_w + addr_w + r + 1) begin
            r++;
        end
        return r + 1;
    endfunction

    // the address only feeds the check bits, it is never stored
    function automatic int codeword_width(input int data_w, input int addr_w);
        return data_w + check_bits(data_w, addr_w);
    endfunction

    // codeword layout, msb first: {parity, hamming bits, data}

    // ----------------------------------------------------------------------
    // decoder result
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        ECC_OK     = 2'b00,
        ECC_SINGLE = 2'b01,   // corrected
        ECC_DOUBLE = 2'b10    // uncorrectable
    } ecc_status_e;

endpackage

`default_nettype wire

// File: src/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

    // ----------------------------------------------------------------------
    // default geometry, the top level overrides these
    // ----------------------------------------------------------------------
    localparam int DEF_DATA_WIDTH     = 32;
    localparam int DEF_ADDR_WIDTH     = 4;    // 16 words in the core
    localparam int DEF_RAM_PIPE_STAGE = 2;    // ram read latency

    // count runs 0 .. 2**addr_w inclusive
    function automatic int count_width(input int addr_w);
        return addr_w + 1;
    endfunction

    // ram stages + decoder register + one slot for the head word
    function automatic int prefetch_slots(input int ram_pipe_stage);
        return ram_pipe_stage + 2;
    endfunction

endpackage

`default_nettype wire
